/* files.f */
hdl/ooo_pkg.sv
hdl/rename_stage.sv
hdl/issue_queue.sv
hdl/alu_exec.sv
hdl/reorder_buffer.sv
hdl/ooo_core_top.sv
sim/ooo_core_sva.sv
sim/ooo_core_tb.sv

/* hdl/alu_exec.sv */
`timescale 1ns/1ps

module alu_exec (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      issue_valid,
    input  ooo_pkg::op_e              issue_op,
    input  logic [ooo_pkg::tag_w-1:0] issue_tag,
    input  logic [ooo_pkg::xlen-1:0]  issue_a,
    input  logic [ooo_pkg::xlen-1:0]  issue_b,
    input  logic [ooo_pkg::xlen-1:0]  issue_pc,
    input  logic [ooo_pkg::xlen-1:0]  issue_imm,
    output logic                      cdb_valid,
    output logic [ooo_pkg::tag_w-1:0] cdb_tag,
    output logic [ooo_pkg::xlen-1:0]  cdb_value,
    output logic                      cdb_taken,
    output logic [ooo_pkg::xlen-1:0]  cdb_target
);

    logic [ooo_pkg::xlen-1:0] result;
    logic                     taken;

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (issue_op)
            ooo_pkg::op_add: result = issue_a + issue_b;
            ooo_pkg::op_sub: result = issue_a - issue_b;
            ooo_pkg::op_and: result = issue_a & issue_b;
            ooo_pkg::op_or:  result = issue_a | issue_b;
            ooo_pkg::op_xor: result = issue_a ^ issue_b;
            ooo_pkg::op_beq: taken = (issue_a == issue_b);
            ooo_pkg::op_bne: taken = (issue_a != issue_b);
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= issue_valid;
        end
        cdb_tag    <= issue_tag;
        cdb_value  <= result;
        cdb_taken  <= taken;
        // branch target, only meaningful for branches
        cdb_target <= issue_pc + issue_imm;
    end

endmodule

/* hdl/issue_queue.sv */
`timescale 1ns/1ps

module issue_queue (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    input  logic                          dispatch_valid,
    input  logic [ooo_pkg::tag_w-1:0]     dispatch_tag,
    input  ooo_pkg::op_e                  dispatch_op,
    input  logic [ooo_pkg::xlen-1:0]      dispatch_a,
    input  logic [ooo_pkg::xlen-1:0]      dispatch_b,
    input  logic                          dispatch_a_valid,
    input  logic                          dispatch_b_valid,
    input  logic [ooo_pkg::tag_w-1:0]     dispatch_a_tag,
    input  logic [ooo_pkg::tag_w-1:0]     dispatch_b_tag,
    input  logic [ooo_pkg::xlen-1:0]      dispatch_pc,
    input  logic [ooo_pkg::xlen-1:0]      dispatch_imm,
    input  logic                          dispatch_imm_used,
    input  logic                          cdb_valid,
    input  logic [ooo_pkg::tag_w-1:0]     cdb_tag,
    input  logic [ooo_pkg::xlen-1:0]      cdb_value,
    output logic                          issue_valid,
    output ooo_pkg::op_e                  issue_op,
    output logic [ooo_pkg::tag_w-1:0]     issue_tag,
    output logic [ooo_pkg::xlen-1:0]      issue_a,
    output logic [ooo_pkg::xlen-1:0]      issue_b,
    output logic [ooo_pkg::xlen-1:0]      issue_pc,
    output logic [ooo_pkg::xlen-1:0]      issue_imm,
    output logic [ooo_pkg::iq_cnt_w-1:0]  iq_free
);

    logic [ooo_pkg::iq_depth-1:0] valid, a_ok, b_ok, imm_used, ready;
    ooo_pkg::op_e                 op    [ooo_pkg::iq_depth];
    logic [ooo_pkg::tag_w-1:0]    tag   [ooo_pkg::iq_depth];
    logic [ooo_pkg::tag_w-1:0]    a_tag [ooo_pkg::iq_depth];
    logic [ooo_pkg::tag_w-1:0]    b_tag [ooo_pkg::iq_depth];
    logic [ooo_pkg::xlen-1:0]     a     [ooo_pkg::iq_depth];
    logic [ooo_pkg::xlen-1:0]     b     [ooo_pkg::iq_depth];
    logic [ooo_pkg::xlen-1:0]     pc    [ooo_pkg::iq_depth];
    logic [ooo_pkg::xlen-1:0]     imm   [ooo_pkg::iq_depth];
    // age matrix: bit j of older[i] set when entry j is older than entry i
    logic [ooo_pkg::iq_depth-1:0] older [ooo_pkg::iq_depth];
    logic [ooo_pkg::iq_idx_w-1:0] sel, slot;

    assign ready = valid & a_ok & b_ok;

    // oldest ready entry has no ready entry older than itself
    always_comb begin
        sel         = '0;
        issue_valid = 1'b0;
        for (int i = 0; i < ooo_pkg::iq_depth; i++) begin
            if (ready[i] && !(|(ready & older[i]))) begin
                sel         = ooo_pkg::iq_idx_w'(i);
                issue_valid = 1'b1;
            end
        end
    end

    // lowest free slot and free count
    always_comb begin
        slot    = '0;
        iq_free = '0;
        for (int i = ooo_pkg::iq_depth - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                slot    = ooo_pkg::iq_idx_w'(i);
                iq_free = iq_free + 1'b1;
            end
        end
    end

    assign issue_op  = op[sel];
    assign issue_tag = tag[sel];
    assign issue_a   = a[sel];
    assign issue_b   = imm_used[sel] ? imm[sel] : b[sel];
    assign issue_pc  = pc[sel];
    assign issue_imm = imm[sel];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid <= '0;
        end else begin
            if (issue_valid) begin
                valid[sel] <= 1'b0;
            end
            // wakeup from the broadcast
            for (int i = 0; i < ooo_pkg::iq_depth; i++) begin
                if (cdb_valid && !a_ok[i] && a_tag[i] == cdb_tag) begin
                    a_ok[i] <= 1'b1;
                    a[i]    <= cdb_value;
                end
                if (cdb_valid && !b_ok[i] && b_tag[i] == cdb_tag) begin
                    b_ok[i] <= 1'b1;
                    b[i]    <= cdb_value;
                end
            end
            if (dispatch_valid) begin
                valid[slot]    <= 1'b1;
                op[slot]       <= dispatch_op;
                tag[slot]      <= dispatch_tag;
                a_tag[slot]    <= dispatch_a_tag;
                b_tag[slot]    <= dispatch_b_tag;
                pc[slot]       <= dispatch_pc;
                imm[slot]      <= dispatch_imm;
                imm_used[slot] <= dispatch_imm_used;
                // same-cycle broadcast hit
                if (!dispatch_a_valid && cdb_valid && cdb_tag == dispatch_a_tag) begin
                    a_ok[slot] <= 1'b1;
                    a[slot]    <= cdb_value;
                end else begin
                    a_ok[slot] <= dispatch_a_valid;
                    a[slot]    <= dispatch_a;
                end
                if (!dispatch_b_valid && cdb_valid && cdb_tag == dispatch_b_tag) begin
                    b_ok[slot] <= 1'b1;
                    b[slot]    <= cdb_value;
                end else begin
                    b_ok[slot] <= dispatch_b_valid;
                    b[slot]    <= dispatch_b;
                end
                older[slot] <= valid;
                for (int i = 0; i < ooo_pkg::iq_depth; i++) begin
                    older[i][slot] <= 1'b0;
                end
            end
        end
    end

endmodule

/* hdl/ooo_core_top.sv */
`timescale 1ns/1ps

module ooo_core_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      insn_valid,
    input  ooo_pkg::insn_u            insn,
    input  logic [ooo_pkg::xlen-1:0]  insn_pc,
    input  logic                      insn_pred_taken,
    output logic                      stall,
    output logic                      commit_valid,
    output logic [ooo_pkg::reg_w-1:0] commit_rd,
    output logic [ooo_pkg::xlen-1:0]  commit_value,
    output logic                      redirect_valid,
    output logic [ooo_pkg::xlen-1:0]  redirect_pc
);

    logic [ooo_pkg::tag_w-1:0]    alloc_tag, query_tag_a, query_tag_b, commit_tag;
    logic                         rob_full, query_ready_a, query_ready_b, flush;
    logic [ooo_pkg::xlen-1:0]     query_value_a, query_value_b;
    logic                         dispatch_valid, dispatch_is_branch, dispatch_pred_taken;
    logic [ooo_pkg::tag_w-1:0]    dispatch_tag, dispatch_a_tag, dispatch_b_tag;
    logic [ooo_pkg::reg_w-1:0]    dispatch_rd;
    ooo_pkg::op_e                 dispatch_op, issue_op;
    logic [ooo_pkg::xlen-1:0]     dispatch_pc, dispatch_a, dispatch_b, dispatch_imm;
    logic                         dispatch_a_valid, dispatch_b_valid, dispatch_imm_used;
    logic                         issue_valid, cdb_valid, cdb_taken;
    logic [ooo_pkg::tag_w-1:0]    issue_tag, cdb_tag;
    logic [ooo_pkg::xlen-1:0]     issue_a, issue_b, issue_pc, issue_imm;
    logic [ooo_pkg::xlen-1:0]     cdb_value, cdb_target;
    logic [ooo_pkg::iq_cnt_w-1:0] iq_free;

    // the entry in flight from rename already owns an iq slot
    assign stall = rob_full || iq_free == '0
                   || (iq_free == ooo_pkg::iq_cnt_w'(1) && dispatch_valid);

    rename_stage u_rename (.*);

    issue_queue u_iq (.*);

    alu_exec u_alu (.*);

    reorder_buffer u_rob (.*);

endmodule

/* hdl/ooo_pkg.sv */
package ooo_pkg;

    // sizing
    localparam int xlen      = 32;
    localparam int rob_depth = 8;
    localparam int tag_w     = 3;
    localparam int iq_depth  = 4;
    localparam int reg_w     = 5;

    // derived widths for counters and indices
    localparam int rob_cnt_w = 4;
    localparam int iq_idx_w  = 2;
    localparam int iq_cnt_w  = 3;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_beq,
        op_bne
    } op_e;

    // rv32i encodings for the supported subset
    localparam logic [6:0] opc_rtype  = 7'b0110011;
    localparam logic [6:0] opc_itype  = 7'b0010011;
    localparam logic [6:0] opc_branch = 7'b1100011;

    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;

    localparam logic [6:0] f7_sub = 7'b0100000;

    typedef struct packed {
        logic [6:0]       funct7;
        logic [reg_w-1:0] rs2;
        logic [reg_w-1:0] rs1;
        logic [2:0]       funct3;
        logic [reg_w-1:0] rd;
        logic [6:0]       opcode;
    } r_view_t;

    // imm_lo sits in the rs2 slot; branches also spread imm bits over rd
    typedef struct packed {
        logic [6:0]       imm_hi;
        logic [4:0]       imm_lo;
        logic [reg_w-1:0] rs1;
        logic [2:0]       funct3;
        logic [reg_w-1:0] rd;
        logic [6:0]       opcode;
    } i_view_t;

    typedef union packed {
        r_view_t r;
        i_view_t i;
    } insn_u;

endpackage

/* hdl/rename_stage.sv */
`timescale 1ns/1ps

module rename_stage (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         insn_valid,
    input  ooo_pkg::insn_u               insn,
    input  logic [ooo_pkg::xlen-1:0]     insn_pc,
    input  logic                         insn_pred_taken,
    input  logic [ooo_pkg::tag_w-1:0]    alloc_tag,
    input  logic                         query_ready_a,
    input  logic                         query_ready_b,
    input  logic [ooo_pkg::xlen-1:0]     query_value_a,
    input  logic [ooo_pkg::xlen-1:0]     query_value_b,
    input  logic                         commit_valid,
    input  logic [ooo_pkg::reg_w-1:0]    commit_rd,
    input  logic [ooo_pkg::xlen-1:0]     commit_value,
    input  logic [ooo_pkg::tag_w-1:0]    commit_tag,
    input  logic                         flush,
    output logic [ooo_pkg::tag_w-1:0]    query_tag_a,
    output logic [ooo_pkg::tag_w-1:0]    query_tag_b,
    output logic                         dispatch_valid,
    output logic [ooo_pkg::tag_w-1:0]    dispatch_tag,
    output logic [ooo_pkg::reg_w-1:0]    dispatch_rd,
    output logic                         dispatch_is_branch,
    output logic                         dispatch_pred_taken,
    output logic [ooo_pkg::xlen-1:0]     dispatch_pc,
    output ooo_pkg::op_e                 dispatch_op,
    output logic [ooo_pkg::xlen-1:0]     dispatch_a,
    output logic [ooo_pkg::xlen-1:0]     dispatch_b,
    output logic                         dispatch_a_valid,
    output logic                         dispatch_b_valid,
    output logic [ooo_pkg::tag_w-1:0]    dispatch_a_tag,
    output logic [ooo_pkg::tag_w-1:0]    dispatch_b_tag,
    output logic [ooo_pkg::xlen-1:0]     dispatch_imm,
    output logic                         dispatch_imm_used
);

    logic [ooo_pkg::xlen-1:0]  rf   [2**ooo_pkg::reg_w];
    logic [ooo_pkg::tag_w-1:0] rtag [2**ooo_pkg::reg_w];
    logic [2**ooo_pkg::reg_w-1:0] busy;

    ooo_pkg::op_e              op;
    logic [ooo_pkg::reg_w-1:0] rs1, rs2, rd;
    logic                      use_rs2, writes_rd, is_branch, imm_used;
    logic [ooo_pkg::xlen-1:0]  imm, a_val, b_val;
    logic                      a_ok, b_ok;

    // decode
    always_comb begin
        rs1       = insn.r.rs1;
        rs2       = insn.r.rs2;
        rd        = insn.r.rd;
        op        = ooo_pkg::op_add;
        use_rs2   = 1'b0;
        writes_rd = 1'b0;
        is_branch = 1'b0;
        imm_used  = 1'b0;
        imm       = '0;
        case (insn.r.opcode)
            ooo_pkg::opc_rtype: begin
                use_rs2   = 1'b1;
                writes_rd = 1'b1;
                case (insn.r.funct3)
                    ooo_pkg::f3_add: begin
                        op = (insn.r.funct7 == ooo_pkg::f7_sub) ? ooo_pkg::op_sub
                                                                : ooo_pkg::op_add;
                    end
                    ooo_pkg::f3_xor: op = ooo_pkg::op_xor;
                    ooo_pkg::f3_or:  op = ooo_pkg::op_or;
                    ooo_pkg::f3_and: op = ooo_pkg::op_and;
                    default:         op = ooo_pkg::op_add;
                endcase
            end
            ooo_pkg::opc_itype: begin
                // addi only
                writes_rd = (insn.i.funct3 == ooo_pkg::f3_add);
                imm_used  = 1'b1;
                imm = {{20{insn.i.imm_hi[6]}}, insn.i.imm_hi, insn.i.imm_lo};
            end
            ooo_pkg::opc_branch: begin
                use_rs2   = 1'b1;
                is_branch = 1'b1;
                op = (insn.i.funct3 == ooo_pkg::f3_beq) ? ooo_pkg::op_beq : ooo_pkg::op_bne;
                imm = {{20{insn.i.imm_hi[6]}}, insn.i.rd[0], insn.i.imm_hi[5:0],
                       insn.i.rd[4:1], 1'b0};
            end
            default: ;
        endcase
    end

    assign query_tag_a = rtag[rs1];
    assign query_tag_b = rtag[rs2];

    // operand read: regfile, value committing this cycle, or rob
    always_comb begin
        if (!busy[rs1]) begin
            a_val = rf[rs1];
            a_ok  = 1'b1;
        end else if (commit_valid && commit_tag == rtag[rs1]) begin
            a_val = commit_value;
            a_ok  = 1'b1;
        end else begin
            a_val = query_value_a;
            a_ok  = query_ready_a;
        end
        if (!use_rs2) begin
            b_val = '0;
            b_ok  = 1'b1;
        end else if (!busy[rs2]) begin
            b_val = rf[rs2];
            b_ok  = 1'b1;
        end else if (commit_valid && commit_tag == rtag[rs2]) begin
            b_val = commit_value;
            b_ok  = 1'b1;
        end else begin
            b_val = query_value_b;
            b_ok  = query_ready_b;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
            for (int i = 0; i < 2**ooo_pkg::reg_w; i++) begin
                rf[i] <= '0;
            end
        end else begin
            if (commit_valid && commit_rd != '0) begin
                rf[commit_rd] <= commit_value;
                if (rtag[commit_rd] == commit_tag) begin
                    busy[commit_rd] <= 1'b0;
                end
            end
            // new producer overrides a same-edge commit clear
            if (flush) begin
                busy <= '0;
            end else if (insn_valid && writes_rd && rd != '0) begin
                busy[rd] <= 1'b1;
                rtag[rd] <= alloc_tag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            dispatch_valid <= 1'b0;
        end else begin
            dispatch_valid <= insn_valid;
        end
        dispatch_tag        <= alloc_tag;
        dispatch_rd         <= writes_rd ? rd : '0;
        dispatch_is_branch  <= is_branch;
        dispatch_pred_taken <= insn_pred_taken;
        dispatch_pc         <= insn_pc;
        dispatch_op         <= op;
        dispatch_a          <= a_val;
        dispatch_b          <= b_val;
        dispatch_a_valid    <= a_ok;
        dispatch_b_valid    <= b_ok;
        dispatch_a_tag      <= rtag[rs1];
        dispatch_b_tag      <= rtag[rs2];
        dispatch_imm        <= imm;
        dispatch_imm_used   <= imm_used;
    end

endmodule

/* hdl/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dispatch_valid,
    input  logic [ooo_pkg::tag_w-1:0] dispatch_tag,
    input  logic [ooo_pkg::reg_w-1:0] dispatch_rd,
    input  logic                      dispatch_is_branch,
    input  logic                      dispatch_pred_taken,
    input  logic [ooo_pkg::xlen-1:0]  dispatch_pc,
    input  logic                      cdb_valid,
    input  logic [ooo_pkg::tag_w-1:0] cdb_tag,
    input  logic [ooo_pkg::xlen-1:0]  cdb_value,
    input  logic                      cdb_taken,
    input  logic [ooo_pkg::xlen-1:0]  cdb_target,
    input  logic [ooo_pkg::tag_w-1:0] query_tag_a,
    input  logic [ooo_pkg::tag_w-1:0] query_tag_b,
    output logic [ooo_pkg::tag_w-1:0] alloc_tag,
    output logic                      rob_full,
    output logic                      query_ready_a,
    output logic                      query_ready_b,
    output logic [ooo_pkg::xlen-1:0]  query_value_a,
    output logic [ooo_pkg::xlen-1:0]  query_value_b,
    output logic                      commit_valid,
    output logic [ooo_pkg::reg_w-1:0] commit_rd,
    output logic [ooo_pkg::xlen-1:0]  commit_value,
    output logic [ooo_pkg::tag_w-1:0] commit_tag,
    output logic                      redirect_valid,
    output logic [ooo_pkg::xlen-1:0]  redirect_pc,
    output logic                      flush
);

    logic [ooo_pkg::rob_depth-1:0] busy, done, is_br, pred, taken;
    logic [ooo_pkg::reg_w-1:0]     rd     [ooo_pkg::rob_depth];
    logic [ooo_pkg::xlen-1:0]      value  [ooo_pkg::rob_depth];
    logic [ooo_pkg::xlen-1:0]      target [ooo_pkg::rob_depth];
    logic [ooo_pkg::xlen-1:0]      pc     [ooo_pkg::rob_depth];

    logic [ooo_pkg::tag_w-1:0]     head, tail;
    logic [ooo_pkg::rob_cnt_w-1:0] count;
    logic                          empty, head_ready, mispredict, retire;

    assign empty      = (count == '0);
    assign head_ready = !empty && done[head];
    assign mispredict = is_br[head] && (pred[head] != taken[head]);
    assign retire     = head_ready && !mispredict;

    // the tail moves one cycle late, so skip past an entry in flight
    assign alloc_tag = dispatch_valid ? ooo_pkg::tag_w'(tail + 1'b1) : tail;
    assign rob_full  = (count + ooo_pkg::rob_cnt_w'(dispatch_valid))
                       == ooo_pkg::rob_cnt_w'(ooo_pkg::rob_depth);

    assign redirect_valid = flush;

    // operand lookup, with bypass of this cycle's broadcast
    always_comb begin
        if (cdb_valid && cdb_tag == query_tag_a) begin
            query_ready_a = 1'b1;
            query_value_a = cdb_value;
        end else begin
            query_ready_a = busy[query_tag_a] && done[query_tag_a];
            query_value_a = value[query_tag_a];
        end
        if (cdb_valid && cdb_tag == query_tag_b) begin
            query_ready_b = 1'b1;
            query_value_b = cdb_value;
        end else begin
            query_ready_b = busy[query_tag_b] && done[query_tag_b];
            query_value_b = value[query_tag_b];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy         <= '0;
            done         <= '0;
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            commit_valid <= 1'b0;
            flush        <= 1'b0;
        end else begin
            // branches and x0 writes retire without a commit strobe
            commit_valid <= retire && rd[head] != '0;
            commit_rd    <= rd[head];
            commit_value <= value[head];
            commit_tag   <= head;
            flush        <= head_ready && mispredict;
            redirect_pc  <= taken[head] ? target[head] : pc[head] + 32'd4;
            if (retire) begin
                busy[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            if (cdb_valid) begin
                done[cdb_tag]   <= 1'b1;
                value[cdb_tag]  <= cdb_value;
                taken[cdb_tag]  <= cdb_taken;
                target[cdb_tag] <= cdb_target;
            end
            if (dispatch_valid) begin
                busy[dispatch_tag]  <= 1'b1;
                done[dispatch_tag]  <= 1'b0;
                rd[dispatch_tag]    <= dispatch_rd;
                is_br[dispatch_tag] <= dispatch_is_branch;
                pred[dispatch_tag]  <= dispatch_pred_taken;
                pc[dispatch_tag]    <= dispatch_pc;
                tail                <= tail + 1'b1;
            end
            count <= count + ooo_pkg::rob_cnt_w'(dispatch_valid)
                           - ooo_pkg::rob_cnt_w'(retire);
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module ooo_core_tb -o ooo_core_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/ooo_core_sim 2>&1)
echo "$out"
echo "$out" | grep -q "Simulation finished: PASS" && exit 0 || exit 1

/* sim/ooo_core_sva.sv */
`timescale 1ns/1ps

module ooo_core_sva (
    input logic clk,
    input logic rst,
    input logic commit_valid,
    input logic redirect_valid,
    input logic flush,
    input logic rob_full,
    input logic empty,
    input logic dispatch_valid
);

    // nothing retires in the redirect cycle
    no_commit_on_redirect: assert property (
        @(posedge clk) disable iff (rst) redirect_valid |-> !commit_valid
    ) else $error("commit_valid high while redirect_valid is high");

    // flush is a single pulse that leaves the buffer empty
    flush_clears_rob: assert property (
        @(posedge clk) disable iff (rst) flush |=> !flush && empty
    ) else $error("flush did not empty the reorder buffer within one cycle");

    // once the last entry is claimed the front end must hold off
    no_alloc_when_full: assert property (
        @(posedge clk) disable iff (rst) rob_full |=> !dispatch_valid
    ) else $error("allocation into a full reorder buffer");

endmodule

/* sim/ooo_core_tb.sv */
`timescale 1ns/1ps

module ooo_core_tb;

    logic                     clk;
    logic                     rst;
    logic                     insn_valid;
    ooo_pkg::insn_u           insn;
    logic [31:0]              insn_pc;
    logic                     insn_pred_taken;
    logic                     stall;
    logic                     commit_valid;
    logic [4:0]               commit_rd;
    logic [31:0]              commit_value;
    logic                     redirect_valid;
    logic [31:0]              redirect_pc;

    // architectural model
    logic [31:0] regs [32];
    logic [36:0] exp_q [$];
    logic [31:0] pc;
    logic [31:0] exp_redirect;
    logic        wrong_path;
    logic        redirect_expected;
    logic        stall_seen;
    integer      seed;

    ooo_core_top DUT (.*);

    bind reorder_buffer ooo_core_sva u_sva (
        .clk(clk),
        .rst(rst),
        .commit_valid(commit_valid),
        .redirect_valid(redirect_valid),
        .flush(flush),
        .rob_full(rob_full),
        .empty(empty),
        .dispatch_valid(dispatch_valid)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [11:0] rand_imm();
        logic [31:0] r;
        r = $random(seed);
        return r[11:0];
    endfunction

    function automatic logic branch_outcome(input logic is_bne, input int rs1, input int rs2);
        return is_bne ? (regs[rs1] != regs[rs2]) : (regs[rs1] == regs[rs2]);
    endfunction

    // single-cycle strobe held back while stall or redirect is up
    task automatic send_word(input ooo_pkg::insn_u w, input logic pred);
        int waited;
        waited = 0;
        while (stall || redirect_valid) begin
            waited++;
            assert (waited < 64) else abort_run("timed out waiting for stall to drop");
            @(posedge clk);
            #1;
        end
        insn_valid      = 1'b1;
        insn            = w;
        insn_pc         = pc;
        insn_pred_taken = pred;
        @(posedge clk);
        #1;
        insn_valid = 1'b0;
    endtask

    task automatic expect_write(input int rd, input logic [31:0] value);
        if (!wrong_path && rd != 0) begin
            regs[rd] = value;
            exp_q.push_back({rd[4:0], value});
        end
    endtask

    task automatic exec_rtype(input ooo_pkg::op_e kind, input int rd, input int rs1,
                              input int rs2);
        ooo_pkg::insn_u w;
        logic [31:0]    res;
        w.r.funct7 = (kind == ooo_pkg::op_sub) ? ooo_pkg::f7_sub : 7'b0;
        w.r.rs2    = rs2[4:0];
        w.r.rs1    = rs1[4:0];
        w.r.rd     = rd[4:0];
        w.r.opcode = ooo_pkg::opc_rtype;
        case (kind)
            ooo_pkg::op_sub: begin
                res = regs[rs1] - regs[rs2];
                w.r.funct3 = ooo_pkg::f3_add;
            end
            ooo_pkg::op_and: begin
                res = regs[rs1] & regs[rs2];
                w.r.funct3 = ooo_pkg::f3_and;
            end
            ooo_pkg::op_or: begin
                res = regs[rs1] | regs[rs2];
                w.r.funct3 = ooo_pkg::f3_or;
            end
            ooo_pkg::op_xor: begin
                res = regs[rs1] ^ regs[rs2];
                w.r.funct3 = ooo_pkg::f3_xor;
            end
            default: begin
                res = regs[rs1] + regs[rs2];
                w.r.funct3 = ooo_pkg::f3_add;
            end
        endcase
        send_word(w, 1'b0);
        expect_write(rd, res);
        pc = pc + 32'd4;
    endtask

    task automatic exec_addi(input int rd, input int rs1, input logic [11:0] imm);
        ooo_pkg::insn_u w;
        w.i.imm_hi = imm[11:5];
        w.i.imm_lo = imm[4:0];
        w.i.rs1    = rs1[4:0];
        w.i.funct3 = ooo_pkg::f3_add;
        w.i.rd     = rd[4:0];
        w.i.opcode = ooo_pkg::opc_itype;
        send_word(w, 1'b0);
        expect_write(rd, regs[rs1] + {{20{imm[11]}}, imm});
        pc = pc + 32'd4;
    endtask

    task automatic exec_branch(input logic is_bne, input int rs1, input int rs2,
                               input logic [12:0] off, input logic pred);
        ooo_pkg::insn_u w;
        logic           taken;
        logic [31:0]    target;
        taken      = branch_outcome(is_bne, rs1, rs2);
        target     = pc + {{19{off[12]}}, off};
        // b-type immediate scattered over the i view
        w.i.imm_hi = {off[12], off[10:5]};
        w.i.imm_lo = rs2[4:0];
        w.i.rs1    = rs1[4:0];
        w.i.funct3 = is_bne ? ooo_pkg::f3_bne : ooo_pkg::f3_beq;
        w.i.rd     = {off[4:1], off[11]};
        w.i.opcode = ooo_pkg::opc_branch;
        send_word(w, pred);
        if (!wrong_path && taken != pred) begin
            exp_redirect      = taken ? target : pc + 32'd4;
            redirect_expected = 1'b1;
            wrong_path        = 1'b1;
        end
        pc = pred ? target : pc + 32'd4;
    endtask

    task automatic wait_redirect();
        int waited;
        waited = 0;
        while (!redirect_valid) begin
            waited++;
            assert (waited < 64) else abort_run("timed out waiting for the redirect");
            @(posedge clk);
            #1;
        end
        assert (redirect_pc == exp_redirect) else abort_run($sformatf(
            "Error at %0t: redirect_pc %h, expected %h", $time, redirect_pc, exp_redirect));
        @(posedge clk);
        #1;
        redirect_expected = 1'b0;
        wrong_path        = 1'b0;
        pc                = exp_redirect;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            assert (waited < 200) else abort_run("timed out waiting for the last commit");
            @(posedge clk);
            #1;
        end
        // idle a little so a stray commit still shows up
        repeat (4) @(posedge clk);
        #1;
    endtask

    always @(negedge clk) begin : commit_check
        logic [36:0] head_exp;
        if (!rst) begin
            if (stall) begin
                stall_seen = 1'b1;
            end
            if (redirect_valid) begin
                assert (redirect_expected) else abort_run("redirect without a mispredicted branch");
            end
            if (commit_valid) begin
                assert (exp_q.size() != 0) else abort_run("commit with nothing left to retire");
                head_exp = exp_q.pop_front();
                assert (commit_rd == head_exp[36:32] && commit_value == head_exp[31:0])
                else abort_run($sformatf("Error at %0t: commit x%0d=%h, expected x%0d=%h",
                    $time, commit_rd, commit_value, head_exp[36:32], head_exp[31:0]));
            end
        end
    end

    task automatic chain_test();
        exec_addi(1, 0, rand_imm());
        exec_addi(2, 0, rand_imm());
        exec_addi(3, 0, rand_imm());
        exec_addi(4, 0, rand_imm());
        exec_rtype(ooo_pkg::op_add, 5, 1, 2);
        exec_rtype(ooo_pkg::op_sub, 6, 5, 3);
        exec_rtype(ooo_pkg::op_xor, 7, 6, 4);
        exec_rtype(ooo_pkg::op_or, 8, 7, 1);
        exec_rtype(ooo_pkg::op_and, 9, 8, 2);
        exec_rtype(ooo_pkg::op_add, 10, 9, 9);
        wait_drain();
    endtask

    task automatic x0_test();
        exec_addi(0, 1, rand_imm());
        exec_addi(11, 0, rand_imm());
        exec_rtype(ooo_pkg::op_or, 12, 0, 0);
        exec_addi(13, 11, rand_imm());
        exec_rtype(ooo_pkg::op_add, 14, 0, 13);
        wait_drain();
    endtask

    task automatic predicted_branch_test();
        exec_branch(1'b0, 1, 1, 13'h020, 1'b1);
        exec_rtype(ooo_pkg::op_add, 15, 5, 6);
        exec_branch(1'b1, 3, 3, 13'h040, 1'b0);
        exec_addi(16, 15, rand_imm());
        exec_branch(1'b1, 1, 2, 13'h1ff0, branch_outcome(1'b1, 1, 2));
        exec_rtype(ooo_pkg::op_xor, 17, 16, 15);
        wait_drain();
    endtask

    task automatic mispredict_test();
        exec_rtype(ooo_pkg::op_add, 17, 1, 2);
        exec_branch(1'b0, 17, 17, 13'h080, 1'b0);
        // wrong-path instructions get flushed
        exec_addi(5, 0, 12'h123);
        exec_rtype(ooo_pkg::op_xor, 18, 5, 5);
        wait_redirect();
        exec_rtype(ooo_pkg::op_add, 19, 5, 0);
        exec_branch(1'b1, 19, 5, 13'h010, 1'b1);
        exec_addi(20, 0, 12'h001);
        wait_redirect();
        exec_addi(21, 5, rand_imm());
        wait_drain();
    endtask

    task automatic burst_test();
        stall_seen = 1'b0;
        // dependent chain ahead of the burst backs up the issue queue
        exec_addi(22, 0, rand_imm());
        exec_rtype(ooo_pkg::op_add, 22, 22, 1);
        exec_rtype(ooo_pkg::op_xor, 22, 22, 2);
        exec_rtype(ooo_pkg::op_sub, 22, 22, 3);
        for (int i = 0; i < 12; i++) begin
            exec_rtype(ooo_pkg::op_e'(i % 5), 10 + i, 22, 1 + i % 4);
        end
        wait_drain();
        assert (stall_seen) else abort_run("stall never rose during the burst");
        assert (!stall) else abort_run("stall still high after the burst drained");
    endtask

    initial begin
        seed              = 32'hd365;
        clk               = 1'b0;
        rst               = 1'b1;
        insn_valid        = 1'b0;
        insn              = '0;
        insn_pc           = '0;
        insn_pred_taken   = 1'b0;
        pc                = '0;
        exp_redirect      = '0;
        wrong_path        = 1'b0;
        redirect_expected = 1'b0;
        stall_seen        = 1'b0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        chain_test();
        x0_test();
        predicted_branch_test();
        mispredict_test();
        burst_test();
        if (exp_q.size() == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
